// ==== dv/conv_tb.sv ====
`timescale 1ns/10ps
`include "conv_cfg.svh"

module conv_tb;
  localparam int H = `ARRAY_HEIGHT;
  localparam int W = `ARRAY_WIDTH;
  localparam int N_VEC = 1 + 60 + 30 + 3;
  localparam int LIMIT_CYCLES = 40 * N_VEC + 200;

  typedef logic [`IFMAP_WIDTH-1:0] vec_t [H];

  logic                     clk;
  logic                     rst_n;
  logic [`WEIGHT_WIDTH-1:0] weights_dat;
  logic                     weights_vld;
  logic                     weights_rdy;
  logic [`IFMAP_WIDTH-1:0]  ifmap_dat;
  logic                     ifmap_vld;
  logic                     ifmap_rdy;
  logic [`OFMAP_WIDTH-1:0]  ofmap_dat;
  logic                     ofmap_vld;
  logic                     ofmap_rdy;

  logic [`WEIGHT_WIDTH-1:0] wmat [H][W];  // reference weights
  logic [`OFMAP_WIDTH-1:0]  exp_q [$];
  logic                     rdy_pattern [1024];
  bit                       rdy_random;
  bit                       weights_done;
  bit                       saw_ifmap_stall;
  int                       stall_run;
  int                       rdy_idx;
  int                       recv_cnt;
  int                       value_errors;
  int                       protocol_errors;
  string                    test_name;

  conv_top i_conv_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .weights_dat(weights_dat),
    .weights_vld(weights_vld),
    .weights_rdy(weights_rdy),
    .ifmap_dat  (ifmap_dat),
    .ifmap_vld  (ifmap_vld),
    .ifmap_rdy  (ifmap_rdy),
    .ofmap_dat  (ofmap_dat),
    .ofmap_vld  (ofmap_vld),
    .ofmap_rdy  (ofmap_rdy)
  );

  always #4 clk = ~clk;

  // sink ready from the 30 percent pattern when random
  always @(posedge clk) begin
    #1;
    ofmap_rdy = rdy_random ? rdy_pattern[rdy_idx] : 1'b1;
    rdy_idx = (rdy_idx + 1) % 1024;
  end

  a_ofmap_held: assert property (@(posedge clk) disable iff (!rst_n)
      (ofmap_vld && !ofmap_rdy) |=> (ofmap_vld && $stable(ofmap_dat)))
    else begin
      protocol_errors++;
      $display("[%s] ofmap word changed or dropped while the sink was stalling", test_name);
    end

  a_weights_closed: assert property (@(posedge clk) disable iff (!rst_n)
      weights_done |-> !weights_rdy)
    else begin
      protocol_errors++;
      $display("[%s] weights_rdy came back after the weight load", test_name);
    end

  // sampled mid-cycle before the transfer edge
  always @(negedge clk) begin
    if (rst_n && ofmap_vld && ofmap_rdy) begin
      assert (exp_q.size() > 0) else begin
        protocol_errors++;
        $display("[%s] ofmap word %h arrived with nothing expected", test_name, ofmap_dat);
      end
      if (exp_q.size() > 0) begin
        assert (ofmap_dat == exp_q[0]) else begin
          value_errors++;
          $display("[ERROR] %s: expected %h, actual %h", test_name, exp_q[0], ofmap_dat);
        end
        void'(exp_q.pop_front());
      end
      recv_cnt++;
    end
    // a stall longer than the one issue cycle comes from back-pressure
    if (rst_n && weights_done && ifmap_vld && !ifmap_rdy) begin
      stall_run++;
      if (stall_run > 1) saw_ifmap_stall = 1'b1;
    end else begin
      stall_run = 0;
    end
  end

  // sum over rows of ifmap times weight mod 2^32
  function automatic logic [`OFMAP_WIDTH-1:0] column_sum(input vec_t v, input int c);
    logic [`OFMAP_WIDTH-1:0] acc;
    acc = '0;
    for (int r = 0; r < H; r++) begin
      acc = acc + `OFMAP_WIDTH'(v[r]) * `OFMAP_WIDTH'(wmat[r][c]);
    end
    return acc;
  endfunction

  task automatic apply_reset();
    weights_done = 1'b0;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic check_idle_after_reset();
    @(negedge clk);
    assert (!ofmap_vld && !ifmap_rdy && weights_rdy) else begin
      protocol_errors++;
      $display("[%s] wrong handshake state after reset: ofmap_vld=%b ifmap_rdy=%b weights_rdy=%b",
               test_name, ofmap_vld, ifmap_rdy, weights_rdy);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_weight(input logic [`WEIGHT_WIDTH-1:0] w);
    logic taken;
    weights_dat = w;
    weights_vld = 1'b1;
    do begin
      @(negedge clk);
      taken = weights_rdy;
      @(posedge clk);
    end while (!taken);
    #1;
    weights_vld = 1'b0;
  endtask

  task automatic send_ifmap(input logic [`IFMAP_WIDTH-1:0] d);
    logic taken;
    ifmap_dat = d;
    ifmap_vld = 1'b1;
    do begin
      @(negedge clk);
      taken = ifmap_rdy;
      @(posedge clk);
    end while (!taken);
    #1;
    ifmap_vld = 1'b0;
  endtask

  task automatic load_weights(input bit all_ones);
    logic [`WEIGHT_WIDTH-1:0] w;
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) begin
        w = all_ones ? '1 : `WEIGHT_WIDTH'($urandom);
        wmat[r][c] = w;
        send_weight(w);
      end
    end
    weights_done = 1'b1;
    @(negedge clk);
    assert (ifmap_rdy) else begin
      protocol_errors++;
      $display("[%s] ifmap_rdy did not rise after the weight load", test_name);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_vector(input vec_t v);
    for (int c = 0; c < W; c++) begin
      exp_q.push_back(column_sum(v, c));
    end
    for (int r = 0; r < H; r++) begin
      send_ifmap(v[r]);
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    vec_t v;
    int   cnt0;
    clk = 1'b0;
    rst_n = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    ifmap_dat = '0;
    ifmap_vld = 1'b0;
    ofmap_rdy = 1'b1;
    void'($urandom(32'h790d));
    for (int i = 0; i < 1024; i++) begin
      rdy_pattern[i] = ($urandom_range(99) < 30);
    end

    test_name = "reset";
    apply_reset();
    check_idle_after_reset();

    test_name = "single_vector";
    load_weights(1'b0);
    for (int r = 0; r < H; r++) v[r] = `IFMAP_WIDTH'(r + 1);  // small values
    send_vector(v);
    wait_drained();

    test_name = "back_to_back";
    cnt0 = recv_cnt;
    for (int n = 0; n < 60; n++) begin
      for (int r = 0; r < H; r++) v[r] = `IFMAP_WIDTH'($urandom);
      send_vector(v);
    end
    wait_drained();
    assert (recv_cnt - cnt0 == 60 * W) else begin
      value_errors++;
      $display("[ERROR] %s: expected %0d words, actual %0d", test_name, 60 * W, recv_cnt - cnt0);
    end

    test_name = "backpressure";
    rdy_random = 1'b1;
    saw_ifmap_stall = 1'b0;
    for (int n = 0; n < 30; n++) begin
      for (int r = 0; r < H; r++) v[r] = `IFMAP_WIDTH'($urandom);
      send_vector(v);
    end
    wait_drained();
    rdy_random = 1'b0;
    assert (saw_ifmap_stall) else begin
      protocol_errors++;
      $display("[%s] ifmap_rdy never dropped under back-pressure", test_name);
    end

    test_name = "wrap";
    apply_reset();
    check_idle_after_reset();
    load_weights(1'b1);
    for (int r = 0; r < H; r++) v[r] = '1;
    repeat (3) send_vector(v);
    wait_drained();

    $display("errors: %0d value, %0d protocol, %0d words received",
             value_errors, protocol_errors, recv_cnt);
    if (value_errors + protocol_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(LIMIT_CYCLES * 8);
    $display("timeout after %0d cycles in %s, output stream stalled (%0d value, %0d protocol errors)",
             LIMIT_CYCLES, test_name, value_errors, protocol_errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+source
source/conv_pkg.sv
source/operand_loader.sv
source/input_skew.sv
source/pe.sv
source/systolic_array.sv
source/ofmap_drain.sv
source/conv_top.sv
dv/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the conv testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module conv_tb \
  -Mdir obj_dir -o conv_sim || { echo "run.sh: build failed"; exit 1; }

out=$(./obj_dir/conv_sim)
echo "$out"
echo "$out" | grep -qxF "=== PASS ===" && echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }

// ==== source/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// grid size, rows x columns of PEs
`define ARRAY_HEIGHT 4
`define ARRAY_WIDTH 4

`define IFMAP_WIDTH 16
`define WEIGHT_WIDTH 16
`define OFMAP_WIDTH 32  // psum and ofmap word

// result vectors held in the drain
`define RESULT_DEPTH 2

// index widths, at least one bit
`define ROW_IDX_WIDTH ((`ARRAY_HEIGHT > 1) ? $clog2(`ARRAY_HEIGHT) : 1)
`define COL_IDX_WIDTH ((`ARRAY_WIDTH > 1) ? $clog2(`ARRAY_WIDTH) : 1)

`endif

// ==== source/conv_pkg.sv ====
`include "conv_cfg.svh"

package conv_pkg;

  // ifmap word moving left to right through the grid
  typedef struct packed {
    logic                    vld;
    logic [`IFMAP_WIDTH-1:0] dat;
  } ifmap_link_t;

  // partial sum moving down a column
  typedef struct packed {
    logic                    vld;
    logic [`OFMAP_WIDTH-1:0] dat;
  } psum_link_t;

  // broadcast weight write, picked up by the matching PE
  typedef struct packed {
    logic                      vld;
    logic [`ROW_IDX_WIDTH-1:0] row;
    logic [`COL_IDX_WIDTH-1:0] col;
    logic [`WEIGHT_WIDTH-1:0]  dat;
  } weight_wr_t;

  typedef ifmap_link_t [`ARRAY_HEIGHT-1:0] ifmap_vec_t;  // one per row
  typedef psum_link_t [`ARRAY_WIDTH-1:0] psum_vec_t;     // one per column

  typedef enum logic {
    st_weights,
    st_compute
  } load_state_e;

endpackage

// ==== source/conv_top.sv ====
`timescale 1ns/10ps
`include "conv_cfg.svh"

module conv_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`WEIGHT_WIDTH-1:0] weights_dat,
  input  logic                     weights_vld,
  output logic                     weights_rdy,
  input  logic [`IFMAP_WIDTH-1:0]  ifmap_dat,
  input  logic                     ifmap_vld,
  output logic                     ifmap_rdy,
  output logic [`OFMAP_WIDTH-1:0]  ofmap_dat,
  output logic                     ofmap_vld,
  input  logic                     ofmap_rdy
);
  conv_pkg::weight_wr_t weight_wr;
  conv_pkg::ifmap_vec_t issue_vec;
  conv_pkg::ifmap_vec_t skewed_vec;
  conv_pkg::psum_vec_t  col_psum;
  logic                 array_en;  // global stall, low when results back up

  operand_loader u_operand_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .array_en   (array_en),
    .weights_dat(weights_dat),
    .weights_vld(weights_vld),
    .weights_rdy(weights_rdy),
    .ifmap_dat  (ifmap_dat),
    .ifmap_vld  (ifmap_vld),
    .ifmap_rdy  (ifmap_rdy),
    .weight_wr  (weight_wr),
    .issue_vec  (issue_vec)
  );

  input_skew u_input_skew (
    .clk       (clk),
    .rst_n     (rst_n),
    .array_en  (array_en),
    .issue_vec (issue_vec),
    .skewed_vec(skewed_vec)
  );

  systolic_array u_systolic_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .array_en  (array_en),
    .weight_wr (weight_wr),
    .skewed_vec(skewed_vec),
    .col_psum  (col_psum)
  );

  ofmap_drain u_ofmap_drain (
    .clk      (clk),
    .rst_n    (rst_n),
    .col_psum (col_psum),
    .array_en (array_en),
    .ofmap_dat(ofmap_dat),
    .ofmap_vld(ofmap_vld),
    .ofmap_rdy(ofmap_rdy)
  );

endmodule

// ==== source/input_skew.sv ====
`timescale 1ns/10ps
`include "conv_cfg.svh"

module input_skew (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 array_en,
  input  conv_pkg::ifmap_vec_t issue_vec,
  output conv_pkg::ifmap_vec_t skewed_vec
);
  conv_pkg::ifmap_link_t row_out [`ARRAY_HEIGHT];

  // row r delayed by r enabled cycles
  for (genvar r = 0; r < `ARRAY_HEIGHT; r++) begin : g_row
    if (r == 0) begin : g_thru
      assign row_out[r] = issue_vec[r];
    end else begin : g_dly
      conv_pkg::ifmap_link_t dly [r];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int k = 0; k < r; k++) begin
            dly[k] <= '0;
          end
        end else if (array_en) begin
          dly[0] <= issue_vec[r];
          for (int k = 1; k < r; k++) begin
            dly[k] <= dly[k-1];
          end
        end
      end

      assign row_out[r] = dly[r-1];
    end
  end

  always_comb begin
    for (int r = 0; r < `ARRAY_HEIGHT; r++) begin
      skewed_vec[r] = row_out[r];
    end
  end

endmodule

// ==== source/ofmap_drain.sv ====
`timescale 1ns/10ps
`include "conv_cfg.svh"

module ofmap_drain (
  input  logic                    clk,
  input  logic                    rst_n,
  input  conv_pkg::psum_vec_t     col_psum,
  output logic                    array_en,
  output logic [`OFMAP_WIDTH-1:0] ofmap_dat,
  output logic                    ofmap_vld,
  input  logic                    ofmap_rdy
);
  localparam int CW = `COL_IDX_WIDTH;
  localparam int PW = (`RESULT_DEPTH > 1) ? $clog2(`RESULT_DEPTH) : 1;
  localparam int NW = $clog2(`RESULT_DEPTH + 1);

  conv_pkg::psum_link_t    aligned [`ARRAY_WIDTH];
  logic [`OFMAP_WIDTH-1:0] res_mem [`RESULT_DEPTH][`ARRAY_WIDTH];
  logic [PW-1:0]           wr_ptr;
  logic [PW-1:0]           rd_ptr;
  logic [NW-1:0]           fill;
  logic [CW-1:0]           col_cnt;
  logic                    push;
  logic                    pop;
  logic                    xfer;

  // column c gets W-1-c more stages
  for (genvar c = 0; c < `ARRAY_WIDTH; c++) begin : g_col
    localparam int D = `ARRAY_WIDTH - 1 - c;
    if (D == 0) begin : g_thru
      assign aligned[c] = col_psum[c];
    end else begin : g_dly
      conv_pkg::psum_link_t dly [D];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int k = 0; k < D; k++) begin
            dly[k] <= '0;
          end
        end else if (array_en) begin
          dly[0] <= col_psum[c];
          for (int k = 1; k < D; k++) begin
            dly[k] <= dly[k-1];
          end
        end
      end

      assign aligned[c] = dly[D-1];
    end
  end

  assign xfer      = ofmap_vld && ofmap_rdy;
  assign pop       = xfer && (col_cnt == CW'(`ARRAY_WIDTH - 1));
  assign push      = aligned[0].vld && array_en;  // once per vector
  assign array_en  = (fill != NW'(`RESULT_DEPTH)) || pop;
  assign ofmap_vld = (fill != '0);
  assign ofmap_dat = res_mem[rd_ptr][col_cnt];

  always_ff @(posedge clk) begin
    if (push) begin
      for (int c = 0; c < `ARRAY_WIDTH; c++) begin
        res_mem[wr_ptr][c] <= aligned[c].dat;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      col_cnt <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PW'(`RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PW'(`RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (xfer) col_cnt <= pop ? '0 : col_cnt + 1'b1;
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
    end
  end

endmodule

// ==== source/operand_loader.sv ====
`timescale 1ns/10ps
`include "conv_cfg.svh"

module operand_loader (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     array_en,
  input  logic [`WEIGHT_WIDTH-1:0] weights_dat,
  input  logic                     weights_vld,
  output logic                     weights_rdy,
  input  logic [`IFMAP_WIDTH-1:0]  ifmap_dat,
  input  logic                     ifmap_vld,
  output logic                     ifmap_rdy,
  output conv_pkg::weight_wr_t     weight_wr,
  output conv_pkg::ifmap_vec_t     issue_vec
);
  localparam int RW = `ROW_IDX_WIDTH;
  localparam int CW = `COL_IDX_WIDTH;

  conv_pkg::load_state_e   state;
  logic [RW-1:0]           w_row;
  logic [CW-1:0]           w_col;
  logic [RW-1:0]           in_row;
  logic [`IFMAP_WIDTH-1:0] collect [`ARRAY_HEIGHT];
  logic                    full;  // collect holds a vector waiting to issue
  logic                    w_xfer;
  logic                    i_xfer;
  logic                    w_last_col;

  assign weights_rdy = (state == conv_pkg::st_weights);
  assign ifmap_rdy   = (state == conv_pkg::st_compute) && !full;
  assign w_xfer      = weights_vld && weights_rdy;
  assign i_xfer      = ifmap_vld && ifmap_rdy;
  assign w_last_col  = (w_col == CW'(`ARRAY_WIDTH - 1));

  // weight load, row-major
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= conv_pkg::st_weights;
      w_row     <= '0;
      w_col     <= '0;
      weight_wr <= '0;
    end else begin
      weight_wr.vld <= w_xfer;
      if (w_xfer) begin
        weight_wr.row <= w_row;
        weight_wr.col <= w_col;
        weight_wr.dat <= weights_dat;
        if (w_last_col) begin
          w_col <= '0;
          w_row <= w_row + 1'b1;
          if (w_row == RW'(`ARRAY_HEIGHT - 1)) state <= conv_pkg::st_compute;
        end else begin
          w_col <= w_col + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_xfer) collect[in_row] <= ifmap_dat;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_row    <= '0;
      full      <= 1'b0;
      issue_vec <= '0;
    end else begin
      if (i_xfer) begin
        if (in_row == RW'(`ARRAY_HEIGHT - 1)) begin
          in_row <= '0;
          full   <= 1'b1;
        end else begin
          in_row <= in_row + 1'b1;
        end
      end
      if (array_en) begin
        // bubble unless a whole vector is ready
        for (int r = 0; r < `ARRAY_HEIGHT; r++) begin
          issue_vec[r].vld <= full;
          issue_vec[r].dat <= collect[r];
        end
        if (full) full <= 1'b0;
      end
    end
  end

endmodule

// ==== source/pe.sv ====
`timescale 1ns/10ps
`include "conv_cfg.svh"

module pe #(
  parameter int ROW = 0,
  parameter int COL = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  array_en,
  input  conv_pkg::weight_wr_t  weight_wr,
  input  conv_pkg::ifmap_link_t ifmap_in,
  output conv_pkg::ifmap_link_t ifmap_out,
  input  conv_pkg::psum_link_t  psum_in,
  output conv_pkg::psum_link_t  psum_out
);
  localparam int RW = `ROW_IDX_WIDTH;
  localparam int CW = `COL_IDX_WIDTH;

  logic [`WEIGHT_WIDTH-1:0] weight;
  logic [`OFMAP_WIDTH-1:0]  prod;
  logic                     wr_hit;

  assign wr_hit = weight_wr.vld && (weight_wr.row == RW'(ROW)) && (weight_wr.col == CW'(COL));
  assign prod   = `OFMAP_WIDTH'(ifmap_in.dat) * `OFMAP_WIDTH'(weight);  // unsigned

  always_ff @(posedge clk) begin
    if (wr_hit) weight <= weight_wr.dat;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ifmap_out <= '0;
      psum_out  <= '0;
    end else if (array_en) begin
      ifmap_out    <= ifmap_in;
      psum_out.vld <= ifmap_in.vld;
      psum_out.dat <= psum_in.dat + prod;  // wraps mod 2^32
    end
  end

endmodule

// ==== source/systolic_array.sv ====
`timescale 1ns/10ps
`include "conv_cfg.svh"

module systolic_array (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 array_en,
  input  conv_pkg::weight_wr_t weight_wr,
  input  conv_pkg::ifmap_vec_t skewed_vec,
  output conv_pkg::psum_vec_t  col_psum
);
  // horizontal ifmap links and vertical psum links
  conv_pkg::ifmap_link_t if_link [`ARRAY_HEIGHT][`ARRAY_WIDTH+1];
  conv_pkg::psum_link_t  ps_link [`ARRAY_HEIGHT+1][`ARRAY_WIDTH];

  for (genvar r = 0; r < `ARRAY_HEIGHT; r++) begin : g_left
    assign if_link[r][0] = skewed_vec[r];
  end

  for (genvar c = 0; c < `ARRAY_WIDTH; c++) begin : g_top
    assign ps_link[0][c] = '0;
  end

  for (genvar r = 0; r < `ARRAY_HEIGHT; r++) begin : g_r
    for (genvar c = 0; c < `ARRAY_WIDTH; c++) begin : g_c
      pe #(
        .ROW(r),
        .COL(c)
      ) u_pe (
        .clk      (clk),
        .rst_n    (rst_n),
        .array_en (array_en),
        .weight_wr(weight_wr),
        .ifmap_in (if_link[r][c]),
        .ifmap_out(if_link[r][c+1]),
        .psum_in  (ps_link[r][c]),
        .psum_out (ps_link[r+1][c])
      );
    end
  end

  always_comb begin
    for (int c = 0; c < `ARRAY_WIDTH; c++) begin
      col_psum[c] = ps_link[`ARRAY_HEIGHT][c];  // bottom row
    end
  end

endmodule
